/* common/csr_pkg.sv */
// machine CSR subsystem package
package csr_pkg;

  localparam int xlen = 32;

  // CSR map, machine mode only
  localparam logic [11:0] addr_mstatus  = 12'h300;
  localparam logic [11:0] addr_mie      = 12'h304;
  localparam logic [11:0] addr_mtvec    = 12'h305;
  localparam logic [11:0] addr_mscratch = 12'h340;
  localparam logic [11:0] addr_mepc     = 12'h341;
  localparam logic [11:0] addr_mcause   = 12'h342;
  localparam logic [11:0] addr_mtval    = 12'h343;
  localparam logic [11:0] addr_mip      = 12'h344;
  // custom timer registers
  localparam logic [11:0] addr_mtimecmp = 12'h7c0;
  localparam logic [11:0] addr_mtime    = 12'hb00;

  // mstatus fields, MPP spans two bits from mpp_lo
  localparam int mstatus_mie    = 3;
  localparam int mstatus_mpie   = 7;
  localparam int mstatus_mpp_lo = 11;

  // timer enable and pending bits
  localparam int mie_mtie = 7;
  localparam int mip_mtip = 7;

  localparam logic [xlen-1:0] cause_illegal_inst = 32'd2;
  localparam logic [xlen-1:0] cause_mtimer_irq   = 32'h8000_0007;

  typedef enum logic [1:0] {
    priv_u = 2'b00,
    priv_m = 2'b11
  } priv_e;

  // low bits of funct3
  typedef enum logic [1:0] {
    op_rw = 2'b01,
    op_rs = 2'b10,
    op_rc = 2'b11
  } csr_op_e;

  typedef struct packed {
    csr_op_e         op;
    logic [11:0]     addr;
    logic [xlen-1:0] wdata;
    logic            rs1_zero;
  } csr_req_t;

  typedef struct packed {
    logic [xlen-1:0] rdata;
    logic            illegal;
  } csr_rsp_t;

  typedef enum logic {
    kind_exception = 1'b0,
    kind_mret      = 1'b1
  } trap_kind_e;

  typedef struct packed {
    trap_kind_e      kind;
    logic [3:0]      cause;
    logic [xlen-1:0] epc;
    logic [xlen-1:0] tval;
  } trap_req_t;

  // fsm to csr file, one cycle wide
  typedef struct packed {
    logic            enter;
    logic            leave;
    logic [xlen-1:0] cause;
    logic [xlen-1:0] epc;
    logic [xlen-1:0] tval;
  } trap_upd_t;

  typedef enum logic [1:0] {
    st_idle,
    st_update,
    st_redirect
  } fsm_state_e;

endpackage

/* csr/csr_alu.sv */
// CSR read-modify-write
module csr_alu (
  input  csr_pkg::csr_req_t        csr_req,
  input  logic [csr_pkg::xlen-1:0] rdata_old,
  output logic                     wr_en,
  output logic [csr_pkg::xlen-1:0] wr_data
);
  import csr_pkg::*;

  logic set_clr_wr;

  // csrrs/csrrc with rs1 = x0 are pure reads
  assign set_clr_wr = !csr_req.rs1_zero;

  always_comb begin
    wr_en   = 1'b0;
    wr_data = rdata_old;
    case (csr_req.op)
      op_rw: begin
        wr_en   = 1'b1;
        wr_data = csr_req.wdata;
      end
      op_rs: begin
        wr_en   = set_clr_wr;
        wr_data = rdata_old | csr_req.wdata;
      end
      op_rc: begin
        wr_en   = set_clr_wr;
        wr_data = rdata_old & ~csr_req.wdata;
      end
      // 2'b00 is not a CSR op, no write
      default: begin
        wr_en   = 1'b0;
        wr_data = rdata_old;
      end
    endcase
  end

endmodule

/* csr/csr_file.sv */
// machine CSR register file
module csr_file (
  input  logic                       clk,
  input  logic                       reset_x,
  input  logic                       csr_fire,
  input  logic [11:0]                csr_addr,
  input  logic                       wr_en,
  input  logic [csr_pkg::xlen-1:0]   wr_data,
  input  csr_pkg::trap_upd_t         trap_upd,
  input  logic [csr_pkg::xlen-1:0]   mtime,
  input  logic                       mtip,
  output logic [csr_pkg::xlen-1:0]   rdata_old,
  output logic                       rsp_valid,
  output csr_pkg::csr_rsp_t          rsp,
  output logic [csr_pkg::xlen-1:0]   mtvec,
  output logic [csr_pkg::xlen-1:0]   mepc,
  output logic [csr_pkg::xlen-1:0]   mtimecmp,
  output logic                       irq_enable,
  output csr_pkg::priv_e             priv_mode
);
  import csr_pkg::*;

  logic [xlen-1:0] mstatus_q;
  logic [xlen-1:0] mie_q;
  logic [xlen-1:0] mscratch_q;
  logic [xlen-1:0] mcause_q;
  logic [xlen-1:0] mtval_q;
  logic [xlen-1:0] mip_q;
  logic            addr_ok;
  logic            illegal;
  logic            csr_we;

  // read mux, unmapped addresses read as zero
  always_comb begin
    addr_ok   = 1'b1;
    rdata_old = '0;
    case (csr_addr)
      addr_mstatus:  rdata_old = mstatus_q;
      addr_mie:      rdata_old = mie_q;
      addr_mtvec:    rdata_old = mtvec;
      addr_mscratch: rdata_old = mscratch_q;
      addr_mepc:     rdata_old = mepc;
      addr_mcause:   rdata_old = mcause_q;
      addr_mtval:    rdata_old = mtval_q;
      addr_mtimecmp: rdata_old = mtimecmp;
      addr_mtime:    rdata_old = mtime;
      addr_mip: begin
        rdata_old           = mip_q;
        // pending bit comes live from the timer
        rdata_old[mip_mtip] = mtip;
      end
      default:       addr_ok = 1'b0;
    endcase
  end

  // mtime is read only
  assign illegal = !addr_ok || (csr_addr == addr_mtime && wr_en);
  assign csr_we  = csr_fire && wr_en && !illegal;

  always_ff @(posedge clk) begin
    if (!reset_x) begin
      mstatus_q <= '0;
      mstatus_q[mstatus_mpp_lo+1:mstatus_mpp_lo] <= priv_m;
      mie_q      <= '0;
      mtvec      <= '0;
      mscratch_q <= '0;
      mepc       <= '0;
      mcause_q   <= '0;
      mtval_q    <= '0;
      mip_q      <= '0;
      mtimecmp   <= '1;
      priv_mode  <= priv_m;
    end else if (trap_upd.enter) begin
      mepc     <= trap_upd.epc;
      mcause_q <= trap_upd.cause;
      mtval_q  <= trap_upd.tval;
      mstatus_q[mstatus_mpie] <= mstatus_q[mstatus_mie];
      mstatus_q[mstatus_mie]  <= 1'b0;
      mstatus_q[mstatus_mpp_lo+1:mstatus_mpp_lo] <= priv_mode;
      priv_mode <= priv_m;
    end else if (trap_upd.leave) begin
      mstatus_q[mstatus_mie]  <= mstatus_q[mstatus_mpie];
      mstatus_q[mstatus_mpie] <= 1'b1;
      mstatus_q[mstatus_mpp_lo+1:mstatus_mpp_lo] <= priv_u;
      priv_mode <= priv_e'(mstatus_q[mstatus_mpp_lo+1:mstatus_mpp_lo]);
    end else if (csr_we) begin
      case (csr_addr)
        addr_mstatus:  mstatus_q  <= wr_data;
        addr_mie:      mie_q      <= wr_data;
        addr_mtvec:    mtvec      <= wr_data;
        addr_mscratch: mscratch_q <= wr_data;
        addr_mepc:     mepc       <= wr_data;
        addr_mcause:   mcause_q   <= wr_data;
        addr_mtval:    mtval_q    <= wr_data;
        addr_mip:      mip_q      <= wr_data;
        addr_mtimecmp: mtimecmp   <= wr_data;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_x) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= csr_fire;
    end
  end

  // old value, zeroed when the access is illegal
  always_ff @(posedge clk) begin
    if (csr_fire) begin
      rsp.rdata   <= illegal ? '0 : rdata_old;
      rsp.illegal <= illegal;
    end
  end

  assign irq_enable = mstatus_q[mstatus_mie] && mie_q[mie_mtie];

  // the fsm never enters and returns in one update
  a_upd_onehot: assert property (@(posedge clk) disable iff (!reset_x)
    !(trap_upd.enter && trap_upd.leave));

  // instruction writes and trap updates live in different fsm states
  a_no_write_during_trap: assert property (@(posedge clk) disable iff (!reset_x)
    !(csr_we && (trap_upd.enter || trap_upd.leave)));

endmodule

/* src/mtimer.sv */
// machine timer
module mtimer (
  input  logic                     clk,
  input  logic                     reset_x,
  input  logic [csr_pkg::xlen-1:0] mtimecmp,
  output logic [csr_pkg::xlen-1:0] mtime,
  output logic                     mtip
);
  import csr_pkg::*;

  logic cmp_hit;

  // unsigned compare
  assign cmp_hit = (mtime >= mtimecmp);

  // free running, wraps at 2^32
  always_ff @(posedge clk) begin
    if (!reset_x) begin
      mtime <= '0;
    end else begin
      mtime <= mtime + 1'b1;
    end
  end

  // pending flag lags the counter by one cycle
  always_ff @(posedge clk) begin
    if (!reset_x) begin
      mtip <= 1'b0;
    end else begin
      mtip <= cmp_hit;
    end
  end

endmodule

/* src/trap_fsm.sv */
// trap and interrupt sequencer
module trap_fsm (
  input  logic                     clk,
  input  logic                     reset_x,
  input  logic                     csr_valid,
  input  logic                     trap_valid,
  input  csr_pkg::trap_req_t       trap_req,
  input  logic                     redirect_ready,
  input  logic [csr_pkg::xlen-1:0] cur_pc,
  input  logic [csr_pkg::xlen-1:0] mtvec,
  input  logic [csr_pkg::xlen-1:0] mepc,
  input  logic                     mie_global,
  input  logic                     mtip,
  output logic                     csr_ready,
  output logic                     trap_ready,
  output logic                     csr_fire,
  output csr_pkg::trap_upd_t       trap_upd,
  output logic                     redirect_valid,
  output logic [csr_pkg::xlen-1:0] redirect_pc
);
  import csr_pkg::*;

  fsm_state_e      state;
  logic            idle;
  logic            trap_start;
  logic            irq_take;
  trap_kind_e      pend_kind;
  logic [xlen-1:0] pend_cause;
  logic [xlen-1:0] pend_epc;
  logic [xlen-1:0] pend_tval;

  assign idle       = (state == st_idle);
  assign trap_ready = idle;
  assign trap_start = trap_valid && trap_ready;
  // an explicit trap request wins over the timer
  assign irq_take   = idle && mtip && mie_global && !trap_valid;
  // traps before csr instructions
  assign csr_ready  = idle && !trap_valid && !(mtip && mie_global);
  assign csr_fire   = csr_valid && csr_ready;

  always_ff @(posedge clk) begin
    if (!reset_x) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle:     if (trap_start || irq_take) state <= st_update;
        st_update:   state <= st_redirect;
        st_redirect: if (redirect_ready) state <= st_idle;
        default:     state <= st_idle;
      endcase
    end
  end

  // latch the pending trap
  always_ff @(posedge clk) begin
    if (trap_start) begin
      pend_kind  <= trap_req.kind;
      pend_cause <= {{(xlen-4){1'b0}}, trap_req.cause};
      pend_epc   <= trap_req.epc;
      pend_tval  <= trap_req.tval;
    end else if (irq_take) begin
      pend_kind  <= kind_exception;
      pend_cause <= cause_mtimer_irq;
      pend_epc   <= cur_pc;
      pend_tval  <= '0;
    end
  end

  // target taken while mepc still holds the pre-update value
  always_ff @(posedge clk) begin
    if (state == st_update) begin
      redirect_pc <= (pend_kind == kind_mret) ? mepc : mtvec;
    end
  end

  always_comb begin
    trap_upd.enter = (state == st_update) && (pend_kind == kind_exception);
    trap_upd.leave = (state == st_update) && (pend_kind == kind_mret);
    trap_upd.cause = pend_cause;
    trap_upd.epc   = pend_epc;
    trap_upd.tval  = pend_tval;
  end

  assign redirect_valid = (state == st_redirect);

  a_redirect_stable: assert property (@(posedge clk) disable iff (!reset_x)
    redirect_valid && !redirect_ready |=> $stable(redirect_pc));

  // back-pressure keeps both channels closed
  a_ready_low_held: assert property (@(posedge clk) disable iff (!reset_x)
    state == st_redirect && !redirect_ready |=> !csr_ready && !trap_ready);

endmodule

/* src/trap_unit.sv */
// trap and CSR unit top
module trap_unit (
  input  logic                     clk,
  input  logic                     reset_x,
  input  logic                     csr_valid,
  input  csr_pkg::csr_req_t        csr_req,
  output logic                     csr_ready,
  output logic                     rsp_valid,
  output csr_pkg::csr_rsp_t        rsp,
  input  logic                     trap_valid,
  input  csr_pkg::trap_req_t       trap_req,
  output logic                     trap_ready,
  output logic                     redirect_valid,
  output logic [csr_pkg::xlen-1:0] redirect_pc,
  input  logic                     redirect_ready,
  input  logic [csr_pkg::xlen-1:0] cur_pc,
  output csr_pkg::priv_e           priv_mode
);
  import csr_pkg::*;

  logic            csr_fire;
  logic            wr_en;
  logic [xlen-1:0] wr_data;
  logic [xlen-1:0] rdata_old;
  trap_upd_t       trap_upd;
  logic [xlen-1:0] mtvec;
  logic [xlen-1:0] mepc;
  logic [xlen-1:0] mtimecmp;
  logic [xlen-1:0] mtime;
  logic            mtip;
  logic            irq_enable;

  csr_file u_csr_file (
    .clk        (clk),
    .reset_x    (reset_x),
    .csr_fire   (csr_fire),
    .csr_addr   (csr_req.addr),
    .wr_en      (wr_en),
    .wr_data    (wr_data),
    .trap_upd   (trap_upd),
    .mtime      (mtime),
    .mtip       (mtip),
    .rdata_old  (rdata_old),
    .rsp_valid  (rsp_valid),
    .rsp        (rsp),
    .mtvec      (mtvec),
    .mepc       (mepc),
    .mtimecmp   (mtimecmp),
    .irq_enable (irq_enable),
    .priv_mode  (priv_mode)
  );

  csr_alu u_csr_alu (
    .csr_req   (csr_req),
    .rdata_old (rdata_old),
    .wr_en     (wr_en),
    .wr_data   (wr_data)
  );

  // irq_enable already folds mstatus.mie with mie.mtie
  trap_fsm u_trap_fsm (
    .clk            (clk),
    .reset_x        (reset_x),
    .csr_valid      (csr_valid),
    .trap_valid     (trap_valid),
    .trap_req       (trap_req),
    .redirect_ready (redirect_ready),
    .cur_pc         (cur_pc),
    .mtvec          (mtvec),
    .mepc           (mepc),
    .mie_global     (irq_enable),
    .mtip           (mtip),
    .csr_ready      (csr_ready),
    .trap_ready     (trap_ready),
    .csr_fire       (csr_fire),
    .trap_upd       (trap_upd),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc)
  );

  mtimer u_mtimer (
    .clk      (clk),
    .reset_x  (reset_x),
    .mtimecmp (mtimecmp),
    .mtime    (mtime),
    .mtip     (mtip)
  );

endmodule

/* test/tb_trap_unit.sv */
// trap unit testbench
module tb_trap_unit;
  import csr_pkg::*;

  localparam int num_rand    = 40;
  localparam int num_ops     = 2 * num_rand + 40;
  localparam int cycle_limit = 20 * num_ops + 2000;

  logic            clk;
  logic            reset_x;
  logic            csr_valid;
  csr_req_t        csr_req;
  logic            csr_ready;
  logic            rsp_valid;
  csr_rsp_t        rsp;
  logic            trap_valid;
  trap_req_t       trap_req;
  logic            trap_ready;
  logic            redirect_valid;
  logic [xlen-1:0] redirect_pc;
  logic            redirect_ready;
  logic [xlen-1:0] cur_pc;
  priv_e           priv_mode;

  // shadow registers in reg_index order
  logic [xlen-1:0] shadow [$];
  priv_e           priv_model;
  logic [11:0]     rw_addrs [$];
  csr_rsp_t        exp_q [$];
  string           name_q [$];
  logic [31:0]     cycle_count = '0;
  int              error_count = 0;
  int              check_count = 0;
  int              test_count  = 0;
  int              test_errors = 0;

  trap_unit u_trap_unit (
    .clk            (clk),
    .reset_x        (reset_x),
    .csr_valid      (csr_valid),
    .csr_req        (csr_req),
    .csr_ready      (csr_ready),
    .rsp_valid      (rsp_valid),
    .rsp            (rsp),
    .trap_valid     (trap_valid),
    .trap_req       (trap_req),
    .trap_ready     (trap_ready),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .redirect_ready (redirect_ready),
    .cur_pc         (cur_pc),
    .priv_mode      (priv_mode)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic int reg_index(input logic [11:0] addr);
    case (addr)
      addr_mstatus:  return 0;
      addr_mie:      return 1;
      addr_mtvec:    return 2;
      addr_mscratch: return 3;
      addr_mepc:     return 4;
      addr_mcause:   return 5;
      addr_mtval:    return 6;
      addr_mip:      return 7;
      addr_mtimecmp: return 8;
      default:       return -1;
    endcase
  endfunction

  // mtime trails the cycle count by the reset time
  function automatic logic model_mtip();
    return cycle_count > shadow[reg_index(addr_mtimecmp)];
  endfunction

  // expected response and new value of one CSR instruction
  function automatic void csr_model(input csr_req_t req, output csr_rsp_t exp_rsp,
                                    output logic wr, output logic [xlen-1:0] new_val);
    int              idx;
    logic            wr_intent;
    logic            bad;
    logic [xlen-1:0] old_val;
    idx       = reg_index(req.addr);
    wr_intent = (req.op == op_rw) || !req.rs1_zero;
    old_val   = (idx >= 0) ? shadow[idx] : '0;
    if (req.addr == addr_mip) begin
      old_val[mip_mtip] = model_mtip();
    end
    case (req.op)
      op_rw:   new_val = req.wdata;
      op_rs:   new_val = old_val | req.wdata;
      default: new_val = old_val & ~req.wdata;
    endcase
    // mtime is only ever written here, never read
    bad = (req.addr == addr_mtime) ? wr_intent : (idx < 0);
    exp_rsp.rdata   = bad ? '0 : old_val;
    exp_rsp.illegal = bad;
    wr = !bad && wr_intent;
  endfunction

  // trap entry or mret on the shadow state, returns target and mode
  function automatic void trap_model(input trap_kind_e kind, input logic [xlen-1:0] cause,
                                     input logic [xlen-1:0] epc, input logic [xlen-1:0] tval,
                                     output logic [xlen-1:0] exp_pc, output priv_e exp_priv);
    logic [xlen-1:0] ms;
    ms = shadow[reg_index(addr_mstatus)];
    if (kind == kind_exception) begin
      exp_pc = shadow[reg_index(addr_mtvec)];
      shadow[reg_index(addr_mepc)]   = epc;
      shadow[reg_index(addr_mcause)] = cause;
      shadow[reg_index(addr_mtval)]  = tval;
      ms[mstatus_mpie] = ms[mstatus_mie];
      ms[mstatus_mie]  = 1'b0;
      ms[mstatus_mpp_lo+1:mstatus_mpp_lo] = priv_model;
      priv_model = priv_m;
    end else begin
      exp_pc = shadow[reg_index(addr_mepc)];
      ms[mstatus_mie]  = ms[mstatus_mpie];
      ms[mstatus_mpie] = 1'b1;
      priv_model = priv_e'(ms[mstatus_mpp_lo+1:mstatus_mpp_lo]);
      ms[mstatus_mpp_lo+1:mstatus_mpp_lo] = priv_u;
    end
    shadow[reg_index(addr_mstatus)] = ms;
    exp_priv = priv_model;
  endfunction

  task automatic check_rsp(input string name, input csr_rsp_t exp, input csr_rsp_t act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      $display("mismatch %s: expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_pc(input string name, input logic [xlen-1:0] exp,
                          input logic [xlen-1:0] act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      $display("mismatch %s: expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_priv(input string name, input priv_e exp, input priv_e act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      $display("mismatch %s: expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic report_error(input string text);
    error_count++;
    $display("error: %s", text);
  endtask

  task automatic csr_op(input csr_op_e op, input logic [11:0] addr,
                        input logic [xlen-1:0] wdata, input logic rs1_zero, input string name);
    csr_rsp_t        exp_rsp;
    logic            wr;
    logic [xlen-1:0] new_val;
    @(negedge clk);
    csr_valid        = 1'b1;
    csr_req.op       = op;
    csr_req.addr     = addr;
    csr_req.wdata    = wdata;
    csr_req.rs1_zero = rs1_zero;
    while (!csr_ready) @(negedge clk);
    // accepted at the coming edge
    csr_model(csr_req, exp_rsp, wr, new_val);
    if (wr) begin
      shadow[reg_index(addr)] = new_val;
    end
    exp_q.push_back(exp_rsp);
    name_q.push_back(name);
    @(negedge clk);
    csr_valid = 1'b0;
    if (!rsp_valid) begin
      report_error({"no response in the cycle after ", name, " was accepted"});
    end
  endtask

  task automatic csr_read(input logic [11:0] addr, input string name);
    csr_op(op_rs, addr, $urandom, 1'b1, name);
  endtask

  task automatic trap_op(input trap_kind_e kind, input logic [3:0] cause,
                         input logic [xlen-1:0] epc, input logic [xlen-1:0] tval,
                         input string name);
    logic [xlen-1:0] exp_pc;
    priv_e           exp_priv;
    int              lat;
    @(negedge clk);
    trap_valid     = 1'b1;
    trap_req.kind  = kind;
    trap_req.cause = cause;
    trap_req.epc   = epc;
    trap_req.tval  = tval;
    while (!trap_ready) @(negedge clk);
    trap_model(kind, {28'd0, cause}, epc, tval, exp_pc, exp_priv);
    @(negedge clk);
    trap_valid = 1'b0;
    lat = 1;
    while (!redirect_valid) begin
      @(negedge clk);
      lat++;
    end
    if (lat != 2) begin
      report_error($sformatf("%s redirect came %0d cycles after acceptance", name, lat));
    end
    check_pc(name, exp_pc, redirect_pc);
    check_priv(name, exp_priv, priv_mode);
  endtask

  task automatic end_test(input string name);
    test_count++;
    $display("test %s finished with %0d errors", name, error_count - test_errors);
    test_errors = error_count;
  endtask

  // every response is checked against the queued expectation
  always @(negedge clk) begin
    if (reset_x && rsp_valid) begin
      if (exp_q.size() == 0) begin
        report_error("response arrived with no accepted request");
      end else begin
        check_rsp(name_q.pop_front(), exp_q.pop_front(), rsp);
      end
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("*** FAILED ***");
      $finish;
    end
  end

  initial begin
    logic [11:0]     addr;
    csr_op_e         op;
    logic [xlen-1:0] wdata;
    logic            rs1z;
    logic [xlen-1:0] exp_pc;
    priv_e           exp_priv;
    int              hold;
    void'($urandom(18));
    reset_x        = 1'b0;
    csr_valid      = 1'b0;
    csr_req        = '0;
    trap_valid     = 1'b0;
    trap_req       = '0;
    redirect_ready = 1'b1;
    cur_pc         = '0;
    shadow         = '{32'h1800, 0, 0, 0, 0, 0, 0, 0, 32'hffff_ffff};
    priv_model     = priv_m;
    rw_addrs       = '{addr_mstatus, addr_mie, addr_mtvec, addr_mscratch, addr_mepc,
                       addr_mcause, addr_mtval, addr_mip, addr_mtimecmp};
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset_x = 1'b1;

    for (int i = 0; i < num_rand; i++) begin
      addr = rw_addrs[$urandom_range(8)];
      case ($urandom_range(2))
        0:       op = op_rw;
        1:       op = op_rs;
        default: op = op_rc;
      endcase
      wdata = $urandom;
      rs1z  = (op != op_rw) && ($urandom_range(3) == 0);
      // keep the timer interrupt off and mtimecmp far away
      if (addr == addr_mie && op != op_rc) begin
        wdata[mie_mtie] = 1'b0;
      end
      if (addr == addr_mtimecmp) begin
        wdata[31] = (op != op_rc);
      end
      csr_op(op, addr, wdata, rs1z, "rand_rmw");
      csr_read(addr, "rand_readback");
    end
    end_test("csr_rmw");

    // no machine CSR sits below 0x300
    for (int i = 0; i < 4; i++) begin
      csr_op(op_rw, 12'($urandom_range(12'h2ff)), $urandom, 1'b0, "unmapped");
    end
    csr_op(op_rs, 12'h7c1, $urandom, 1'b0, "unmapped");
    csr_op(op_rw, addr_mtime, $urandom, 1'b0, "mtime_write");
    csr_op(op_rc, addr_mtime, $urandom, 1'b0, "mtime_write");
    foreach (rw_addrs[i]) begin
      csr_read(rw_addrs[i], "illegal_readback");
    end
    end_test("illegal");

    csr_op(op_rs, addr_mstatus, 32'h1 << mstatus_mie, 1'b0, "set_mie");
    trap_op(kind_exception, cause_illegal_inst[3:0], $urandom, $urandom, "exception");
    csr_read(addr_mepc, "exc_mepc");
    csr_read(addr_mcause, "exc_mcause");
    csr_read(addr_mtval, "exc_mtval");
    csr_read(addr_mstatus, "exc_mstatus");
    end_test("exception");

    // mpp = 00 so that mret drops to user mode
    csr_op(op_rc, addr_mstatus, 32'h1800, 1'b0, "clear_mpp");
    trap_op(kind_mret, 4'd0, '0, '0, "mret");
    csr_read(addr_mstatus, "mret_mstatus");
    trap_op(kind_exception, cause_illegal_inst[3:0], $urandom, $urandom, "exception_from_u");
    csr_read(addr_mstatus, "from_u_mstatus");
    end_test("mret");

    @(negedge clk);
    redirect_ready = 1'b0;
    trap_op(kind_exception, cause_illegal_inst[3:0], $urandom, $urandom, "stall_entry");
    hold = $urandom_range(12, 3);
    // a read offered during the stall must not be taken
    csr_valid        = 1'b1;
    csr_req.op       = op_rs;
    csr_req.addr     = addr_mscratch;
    csr_req.rs1_zero = 1'b1;
    repeat (hold) begin
      @(negedge clk);
      check_pc("stall_pc", shadow[reg_index(addr_mtvec)], redirect_pc);
      if (csr_ready || trap_ready) begin
        report_error("a ready signal went high while the redirect was stalled");
      end
      if (!redirect_valid) begin
        report_error("redirect dropped before redirect_ready");
      end
    end
    csr_valid      = 1'b0;
    redirect_ready = 1'b1;
    @(negedge clk);
    if (redirect_valid) begin
      report_error("redirect still valid after it was taken");
    end
    end_test("backpressure");

    cur_pc = $urandom;
    csr_op(op_rs, addr_mie, 32'h1 << mie_mtie, 1'b0, "enable_mtie");
    csr_op(op_rs, addr_mstatus, 32'h1 << mstatus_mie, 1'b0, "enable_mie");
    csr_op(op_rw, addr_mtimecmp, cycle_count + 32'd60, 1'b0, "arm_timer");
    while (!redirect_valid) @(negedge clk);
    trap_model(kind_exception, cause_mtimer_irq, cur_pc, '0, exp_pc, exp_priv);
    check_pc("timer_irq", exp_pc, redirect_pc);
    check_priv("timer_irq", exp_priv, priv_mode);
    csr_read(addr_mcause, "irq_mcause");
    csr_read(addr_mepc, "irq_mepc");
    csr_read(addr_mip, "irq_mip");
    end_test("timer_irq");

    @(negedge clk);
    if (exp_q.size() != 0) begin
      report_error($sformatf("%0d responses never arrived", exp_q.size()));
    end
    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* vlog.f */
common/csr_pkg.sv
csr/csr_alu.sv
csr/csr_file.sv
src/mtimer.sv
src/trap_fsm.sv
src/trap_unit.sv
test/tb_trap_unit.sv

/* Makefile */
TOP = tb_trap_unit

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f vlog.f --top-module trap_unit
	verilator --lint-only --timing -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) \
		--Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q '\*\*\* FAILED \*\*\*' sim.log; then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -q '\*\*\* PASSED \*\*\*' sim.log || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf obj_dir sim.log
